/* logic/frv_defs.svh */
// Core width definitions shared by the execute stage package and modules
`ifndef FRV_DEFS_SVH
`define FRV_DEFS_SVH

// Data word width
`define FRV_XLEN 32

// Shift amount width, log2 of the word width
`define FRV_SHAMT_W 5

`endif

/* logic/frv_pkg.sv */
// Shared types for the RV32I integer execute stage
`default_nettype none

`include "frv_defs.svh"

package frv_pkg;

    typedef logic [`FRV_XLEN-1:0]    xlen_t;    // One data word
    typedef logic [`FRV_SHAMT_W-1:0] shamt_t;   // Shift amount
    typedef logic [4:0]              reg_idx_t; // Register index
    typedef logic [2:0]              funct3_t;  // funct3 field

    // RV32I major opcodes handled by this stage
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        BRANCH = 7'b1100011
    } opcode_e;

endpackage

`default_nettype wire

/* logic/frv_alu_op_if.sv */
// ALU operation strobes and operands passed from the decoder to the ALU
`timescale 1ns/1ps
`default_nettype none

interface frv_alu_op_if;

    logic           op_add;
    logic           op_sub;
    logic           op_xor;
    logic           op_or;
    logic           op_and;
    logic           op_shf;
    logic           op_shf_left;
    logic           op_shf_arith;
    logic           op_cmp;
    logic           op_unsigned;
    frv_pkg::xlen_t lhs;
    frv_pkg::xlen_t rhs;

    modport decode (
        output op_add, op_sub, op_xor, op_or, op_and,
        output op_shf, op_shf_left, op_shf_arith, op_cmp, op_unsigned,
        output lhs, rhs
    );

    modport alu (
        input op_add, op_sub, op_xor, op_or, op_and,
        input op_shf, op_shf_left, op_shf_arith, op_cmp, op_unsigned,
        input lhs, rhs
    );

endinterface

`default_nettype wire

/* logic/frv_alu_decode.sv */
// Instruction decoder that drives ALU strobes and operands and flags branches
`timescale 1ns/1ps
`default_nettype none

module frv_alu_decode (
    input  frv_pkg::opcode_e opcode,
    input  frv_pkg::funct3_t funct3,
    input  logic             funct7_b5,
    input  frv_pkg::xlen_t   pc,
    input  frv_pkg::xlen_t   rs1,
    input  frv_pkg::xlen_t   rs2,
    input  frv_pkg::xlen_t   imm,
    frv_alu_op_if.decode     alu,
    output logic             is_branch,
    output logic             wen,
    output logic             illegal
);

    always_comb begin
        alu.op_add       = 1'b0;
        alu.op_sub       = 1'b0;
        alu.op_xor       = 1'b0;
        alu.op_or        = 1'b0;
        alu.op_and       = 1'b0;
        alu.op_shf       = 1'b0;
        alu.op_shf_left  = 1'b0;
        alu.op_shf_arith = 1'b0;
        alu.op_cmp       = 1'b0;
        alu.op_unsigned  = 1'b0;
        alu.lhs          = rs1;
        alu.rhs          = rs2;
        is_branch        = 1'b0;
        wen              = 1'b1;
        illegal          = 1'b0;

        case (opcode)
            frv_pkg::OP,
            frv_pkg::OP_IMM: begin
                if (opcode == frv_pkg::OP_IMM) begin
                    alu.rhs = imm;
                end
                case (funct3)
                    3'b000: begin
                        alu.op_add = 1'b1;
                        alu.op_sub = (opcode == frv_pkg::OP) && funct7_b5; // No SUBI
                    end
                    3'b001: begin
                        alu.op_shf      = 1'b1;
                        alu.op_shf_left = 1'b1;
                    end
                    3'b010: alu.op_cmp = 1'b1;            // SLT
                    3'b011: begin
                        alu.op_cmp      = 1'b1;           // SLTU
                        alu.op_unsigned = 1'b1;
                    end
                    3'b100: alu.op_xor = 1'b1;
                    3'b101: begin
                        alu.op_shf       = 1'b1;
                        alu.op_shf_arith = funct7_b5;     // SRA vs SRL
                    end
                    3'b110: alu.op_or = 1'b1;
                    default: alu.op_and = 1'b1;
                endcase
            end
            frv_pkg::LUI: begin
                alu.op_add = 1'b1;
                alu.lhs    = '0;
                alu.rhs    = imm;
            end
            frv_pkg::AUIPC: begin
                alu.op_add = 1'b1;
                alu.lhs    = pc;
                alu.rhs    = imm;
            end
            frv_pkg::BRANCH: begin
                // BLTU/BGEU have funct3 bit 1 set
                alu.op_cmp      = 1'b1;
                alu.op_unsigned = funct3[1];
                is_branch       = 1'b1;
                wen             = 1'b0;
            end
            default: begin
                wen     = 1'b0;
                illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/frv_alu.sv */
// Integer ALU with add/sub, compare, shift and bitwise paths
`timescale 1ns/1ps
`default_nettype none

`include "frv_defs.svh"

module frv_alu (
    frv_alu_op_if.alu      alu,
    output logic           alu_lt,          // lhs < rhs
    output logic           alu_eq,          // lhs == rhs
    output frv_pkg::xlen_t alu_add_result,
    output frv_pkg::xlen_t alu_result
);

    frv_pkg::xlen_t          adder_rhs;
    frv_pkg::xlen_t          adder_ci;
    logic                    lt_signed;
    logic                    lt_unsigned;
    logic                    shift_fill;
    logic [2*`FRV_XLEN-1:0]  shift_lhs;
    logic [2*`FRV_XLEN-1:0]  shift_right;
    frv_pkg::shamt_t         shift_amt;
    frv_pkg::xlen_t          shift_result;
    frv_pkg::xlen_t          bw_result;
    logic                    out_adder;
    logic                    out_shift;
    logic                    out_bw;

    // Subtract as lhs + ~rhs + 1
    assign adder_rhs      = alu.op_sub ? ~alu.rhs : alu.rhs;
    assign adder_ci       = {{(`FRV_XLEN-1){1'b0}}, alu.op_sub};
    assign alu_add_result = alu.lhs + adder_rhs + adder_ci;

    assign lt_signed   = $signed(alu.lhs) < $signed(alu.rhs);
    assign lt_unsigned = alu.lhs < alu.rhs;
    assign alu_lt      = alu.op_unsigned ? lt_unsigned : lt_signed;
    assign alu_eq      = alu.lhs == alu.rhs;

    // Upper half filled with the sign bit for SRA
    assign shift_fill   = alu.op_shf_arith && alu.lhs[`FRV_XLEN-1];
    assign shift_lhs    = {{`FRV_XLEN{shift_fill}}, alu.lhs};
    assign shift_amt    = alu.rhs[`FRV_SHAMT_W-1:0];
    assign shift_right  = shift_lhs >> shift_amt;
    assign shift_result = alu.op_shf_left ? (alu.lhs << shift_amt)
                                          : shift_right[`FRV_XLEN-1:0];

    assign bw_result = {`FRV_XLEN{alu.op_xor}} & (alu.lhs ^ alu.rhs) |
                       {`FRV_XLEN{alu.op_or}}  & (alu.lhs | alu.rhs) |
                       {`FRV_XLEN{alu.op_and}} & (alu.lhs & alu.rhs);

    assign out_adder = alu.op_add && !alu.op_cmp;
    assign out_shift = alu.op_shf;
    assign out_bw    = alu.op_xor || alu.op_or || alu.op_and;

    // One-hot AND-OR result select
    assign alu_result = {`FRV_XLEN{out_adder}}  & alu_add_result |
                        {`FRV_XLEN{out_shift}}  & shift_result   |
                        {`FRV_XLEN{out_bw}}     & bw_result      |
                        {`FRV_XLEN{alu.op_cmp}} & {{(`FRV_XLEN-1){1'b0}}, alu_lt};

endmodule

`default_nettype wire

/* logic/frv_branch_unit.sv */
// Branch resolution from ALU compare flags plus branch target adder
`timescale 1ns/1ps
`default_nettype none

module frv_branch_unit (
    input  logic             is_branch,
    input  frv_pkg::funct3_t funct3,
    input  logic             alu_lt,
    input  logic             alu_eq,
    input  frv_pkg::xlen_t   pc,
    input  frv_pkg::xlen_t   imm,
    output logic             br_taken,
    output frv_pkg::xlen_t   br_target
);

    logic base_cond;
    logic cond;

    // BEQ/BNE compare equality and BLT/BGE/BLTU/BGEU use less-than
    assign base_cond = funct3[2] ? alu_lt : alu_eq;

    // Odd funct3 gives the negated form
    assign cond = base_cond ^ funct3[0];

    assign br_taken  = is_branch && cond;
    assign br_target = pc + imm;   // Own adder while the ALU compares

endmodule

`default_nettype wire

/* logic/frv_exec_reg.sv */
// Execute stage output register with valid/ready handshake and flush
`timescale 1ns/1ps
`default_nettype none

module frv_exec_reg (
    input  logic              g_clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              id_valid,
    input  logic              wb_ready,
    input  frv_pkg::reg_idx_t rd_in,
    input  frv_pkg::xlen_t    result_in,
    input  frv_pkg::xlen_t    target_in,
    input  logic              wen_in,
    input  logic              taken_in,
    input  logic              illegal_in,
    output logic              id_ready,
    output logic              ex_valid,
    output frv_pkg::reg_idx_t ex_rd,
    output frv_pkg::xlen_t    ex_result,
    output frv_pkg::xlen_t    ex_br_target,
    output logic              ex_wen,
    output logic              ex_br_taken,
    output logic              ex_illegal
);

    logic accept;

    assign id_ready = !ex_valid || wb_ready;   // Empty, or draining this cycle
    assign accept   = id_valid && id_ready;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;                  // Drops held and offered instruction
        end else if (accept) begin
            ex_valid <= 1'b1;
        end else if (wb_ready) begin
            ex_valid <= 1'b0;
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept && !flush) begin
            ex_rd        <= rd_in;
            ex_result    <= result_in;
            ex_br_target <= target_in;
            ex_wen       <= wen_in;
            ex_br_taken  <= taken_in;
            ex_illegal   <= illegal_in;
        end
    end

endmodule

`default_nettype wire

/* logic/frv_execute.sv */
// Integer execute stage top linking decoder, ALU, branch unit and output register
`timescale 1ns/1ps
`default_nettype none

module frv_execute (
    input  logic              g_clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              id_valid,
    output logic              id_ready,
    input  frv_pkg::opcode_e  id_opcode,
    input  frv_pkg::funct3_t  id_funct3,
    input  logic              id_funct7_b5,
    input  frv_pkg::xlen_t    id_pc,
    input  frv_pkg::xlen_t    id_rs1,
    input  frv_pkg::xlen_t    id_rs2,
    input  frv_pkg::xlen_t    id_imm,
    input  frv_pkg::reg_idx_t id_rd,
    input  logic              wb_ready,
    output logic              ex_valid,
    output frv_pkg::reg_idx_t ex_rd,
    output frv_pkg::xlen_t    ex_result,
    output logic              ex_wen,
    output logic              ex_br_taken,
    output frv_pkg::xlen_t    ex_br_target,
    output logic              ex_illegal
);

    frv_alu_op_if   alu_op ();

    logic           is_branch;
    logic           wen;
    logic           illegal;
    logic           alu_lt;
    logic           alu_eq;
    frv_pkg::xlen_t alu_result;
    logic           br_taken;
    frv_pkg::xlen_t br_target;

    frv_alu_decode frv_alu_decode_i (
        .opcode    (id_opcode),
        .funct3    (id_funct3),
        .funct7_b5 (id_funct7_b5),
        .pc        (id_pc),
        .rs1       (id_rs1),
        .rs2       (id_rs2),
        .imm       (id_imm),
        .alu       (alu_op.decode),
        .is_branch (is_branch),
        .wen       (wen),
        .illegal   (illegal)
    );

    frv_alu frv_alu_i (
        .alu            (alu_op.alu),
        .alu_lt         (alu_lt),
        .alu_eq         (alu_eq),
        .alu_add_result (),             // Branch target has its own adder
        .alu_result     (alu_result)
    );

    frv_branch_unit frv_branch_unit_i (
        .is_branch (is_branch),
        .funct3    (id_funct3),
        .alu_lt    (alu_lt),
        .alu_eq    (alu_eq),
        .pc        (id_pc),
        .imm       (id_imm),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    frv_exec_reg frv_exec_reg_i (
        .g_clk        (g_clk),
        .rst          (rst),
        .flush        (flush),
        .id_valid     (id_valid),
        .wb_ready     (wb_ready),
        .rd_in        (id_rd),
        .result_in    (alu_result),
        .target_in    (br_target),
        .wen_in       (wen),
        .taken_in     (br_taken),
        .illegal_in   (illegal),
        .id_ready     (id_ready),
        .ex_valid     (ex_valid),
        .ex_rd        (ex_rd),
        .ex_result    (ex_result),
        .ex_br_target (ex_br_target),
        .ex_wen       (ex_wen),
        .ex_br_taken  (ex_br_taken),
        .ex_illegal   (ex_illegal)
    );

endmodule

`default_nettype wire

/* testbench/tb_frv_execute.sv */
// Testbench for the integer execute stage with random instructions and a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_frv_execute;

    localparam int RST_CYCLES      = 10;
    localparam int N_TIGHT         = 200;   // wb_ready held high
    localparam int N_LOOSE         = 400;   // Random wb_ready and flush
    localparam int WATCHDOG_CYCLES = (N_TIGHT + N_LOOSE) * 40 + 2 * RST_CYCLES;

    typedef struct packed {
        frv_pkg::reg_idx_t rd;
        frv_pkg::xlen_t    result;
        frv_pkg::xlen_t    target;
        logic              wen;
        logic              taken;
        logic              illegal;
        logic              is_branch;
        logic              chk_result;
    } expect_t;

    logic              g_clk;
    logic              rst;
    logic              flush;
    logic              id_valid;
    logic              id_ready;
    frv_pkg::opcode_e  id_opcode;
    frv_pkg::funct3_t  id_funct3;
    logic              id_funct7_b5;
    frv_pkg::xlen_t    id_pc;
    frv_pkg::xlen_t    id_rs1;
    frv_pkg::xlen_t    id_rs2;
    frv_pkg::xlen_t    id_imm;
    frv_pkg::reg_idx_t id_rd;
    logic              wb_ready;
    logic              ex_valid;
    frv_pkg::reg_idx_t ex_rd;
    frv_pkg::xlen_t    ex_result;
    logic              ex_wen;
    logic              ex_br_taken;
    frv_pkg::xlen_t    ex_br_target;
    logic              ex_illegal;

    expect_t exp_q[$];
    int      check_cnt    = 0;
    int      mismatch_cnt = 0;
    int      other_cnt    = 0;
    int      accepted_cnt = 0;

    frv_execute frv_execute_i (
        .g_clk        (g_clk),
        .rst          (rst),
        .flush        (flush),
        .id_valid     (id_valid),
        .id_ready     (id_ready),
        .id_opcode    (id_opcode),
        .id_funct3    (id_funct3),
        .id_funct7_b5 (id_funct7_b5),
        .id_pc        (id_pc),
        .id_rs1       (id_rs1),
        .id_rs2       (id_rs2),
        .id_imm       (id_imm),
        .id_rd        (id_rd),
        .wb_ready     (wb_ready),
        .ex_valid     (ex_valid),
        .ex_rd        (ex_rd),
        .ex_result    (ex_result),
        .ex_wen       (ex_wen),
        .ex_br_taken  (ex_br_taken),
        .ex_br_target (ex_br_target),
        .ex_illegal   (ex_illegal)
    );

    initial begin
        g_clk = 1'b0;
        forever #10 g_clk = ~g_clk;
    end

    task automatic check_word(input string name, input frv_pkg::xlen_t got,
                              input frv_pkg::xlen_t exp);
        check_cnt++;
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_reg(input string name, input frv_pkg::reg_idx_t got,
                             input frv_pkg::reg_idx_t exp);
        check_cnt++;
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // RV32I semantics for the accepted instruction
    function automatic expect_t predict(input frv_pkg::opcode_e opc, input frv_pkg::funct3_t f3,
                                        input logic f7, input frv_pkg::xlen_t pc,
                                        input frv_pkg::xlen_t rs1, input frv_pkg::xlen_t rs2,
                                        input frv_pkg::xlen_t imm,
                                        input frv_pkg::reg_idx_t rd);
        expect_t               e;
        frv_pkg::xlen_t        b;
        frv_pkg::shamt_t       sh;
        logic signed [31:0]    a_s;
        logic                  lt_s;
        logic                  lt_u;
        e          = '0;
        e.rd       = rd;
        e.target   = pc + imm;
        b          = (opc == frv_pkg::OP_IMM) ? imm : rs2;
        sh         = b[4:0];
        a_s        = rs1;
        lt_s       = $signed(rs1) < $signed(b);
        lt_u       = rs1 < b;
        case (opc)
            frv_pkg::OP, frv_pkg::OP_IMM: begin
                e.wen        = 1'b1;
                e.chk_result = 1'b1;
                case (f3)
                    3'd0: e.result = (opc == frv_pkg::OP && f7) ? rs1 - b : rs1 + b;
                    3'd1: e.result = rs1 << sh;
                    3'd2: e.result = {31'd0, lt_s};
                    3'd3: e.result = {31'd0, lt_u};
                    3'd4: e.result = rs1 ^ b;
                    3'd5: begin
                        if (f7) e.result = a_s >>> sh;
                        else    e.result = rs1 >> sh;
                    end
                    3'd6: e.result = rs1 | b;
                    default: e.result = rs1 & b;
                endcase
            end
            frv_pkg::LUI: begin
                e.wen        = 1'b1;
                e.chk_result = 1'b1;
                e.result     = imm;
            end
            frv_pkg::AUIPC: begin
                e.wen        = 1'b1;
                e.chk_result = 1'b1;
                e.result     = pc + imm;
            end
            frv_pkg::BRANCH: begin
                e.is_branch = 1'b1;
                case (f3)
                    3'd0: e.taken = rs1 == rs2;     // BEQ
                    3'd1: e.taken = rs1 != rs2;
                    3'd4: e.taken = lt_s;           // BLT
                    3'd5: e.taken = !lt_s;
                    3'd6: e.taken = lt_u;           // BLTU
                    default: e.taken = !lt_u;
                endcase
            end
            default: e.illegal = 1'b1;
        endcase
        return e;
    endfunction

    task automatic compare_output(input expect_t e);
        check_reg("ex_rd", ex_rd, e.rd);
        check_bit("ex_wen", ex_wen, e.wen);
        check_bit("ex_illegal", ex_illegal, e.illegal);
        check_bit("ex_br_taken", ex_br_taken, e.taken);
        if (e.chk_result) check_word("ex_result", ex_result, e.result);
        if (e.is_branch) check_word("ex_br_target", ex_br_target, e.target);
    endtask

    // Model follows the handshake at each rising edge
    always @(posedge g_clk) begin : monitor
        expect_t e;
        if (rst) begin
            exp_q.delete();
        end else begin
            check_bit("ex_valid", ex_valid, exp_q.size() != 0);  // One edge after accept
            check_bit("id_ready", id_ready, exp_q.size() == 0 || wb_ready);
            if (ex_valid && wb_ready && exp_q.size() != 0) begin
                e = exp_q.pop_front();
                compare_output(e);
            end
            if (flush) begin
                exp_q.delete();                                   // Held and offered both dropped
            end else if (id_valid && id_ready) begin
                exp_q.push_back(predict(id_opcode, id_funct3, id_funct7_b5, id_pc,
                                        id_rs1, id_rs2, id_imm, id_rd));
                accepted_cnt++;
            end
            if (exp_q.size() > 1) begin
                other_cnt++;
                $display("Stage accepted a second instruction while one was held at %0t", $time);
            end
        end
    end

    task automatic offer_random_instr();
        logic [31:0] pick;
        logic [31:0] r;
        logic [31:0] r2;
        logic [4:0]  shamt;
        pick         = $urandom % 20;
        r            = $urandom;
        r2           = $urandom;
        id_funct3    = r[2:0];
        id_funct7_b5 = 1'b0;
        id_rd        = r[7:3];
        id_pc        = $urandom & 32'hFFFF_FFFC;
        id_rs1       = $urandom;
        id_rs2       = $urandom;
        id_imm       = {{20{r2[11]}}, r2[11:0]};
        case (r[9:8])
            2'd0: shamt = 5'd0;
            2'd1: shamt = 5'd31;
            default: shamt = r[14:10];
        endcase
        if (pick < 12) begin
            id_opcode = (pick < 6) ? frv_pkg::OP : frv_pkg::OP_IMM;
            if (id_funct3 == 3'd5 || (id_funct3 == 3'd0 && pick < 6)) id_funct7_b5 = r[15];
            if (id_funct3 == 3'd1 || id_funct3 == 3'd5) begin
                if (r[16]) id_rs1[31] = 1'b1;                    // Negative for SRA
                if (pick < 6) id_rs2 = {id_rs2[31:5], shamt};
                else          id_imm = {20'd0, 1'b0, id_funct7_b5, 5'd0, shamt};
            end
        end else if (pick < 14) begin
            id_opcode = (pick == 12) ? frv_pkg::LUI : frv_pkg::AUIPC;
            id_imm    = $urandom & 32'hFFFF_F000;
        end else if (pick < 19) begin
            id_opcode = frv_pkg::BRANCH;
            if (id_funct3[2:1] == 2'b01) id_funct3[2] = 1'b1;  // Only the six real branches
            if (r[20:19] == 2'd0) id_rs2 = id_rs1;
            id_imm[0] = 1'b0;
        end else begin
            case (r[22:21])
                2'd0: id_opcode = frv_pkg::opcode_e'(7'b0000011);  // LOAD
                2'd1: id_opcode = frv_pkg::opcode_e'(7'b0100011);  // STORE
                2'd2: id_opcode = frv_pkg::opcode_e'(7'b1101111);  // JAL
                default: id_opcode = frv_pkg::opcode_e'(7'b1110011);
            endcase
        end
    endtask

    task automatic run_phase(input int target, input logic loose);
        @(negedge g_clk);
        while (accepted_cnt < target) begin
            offer_random_instr();
            id_valid = ($urandom % 4) != 0;
            wb_ready = loose ? (($urandom % 3) != 0) : 1'b1;
            flush    = loose && !flush && (($urandom % 20) == 0);
            @(negedge g_clk);
        end
        id_valid = 1'b0;
        flush    = 1'b0;
        wb_ready = 1'b1;
        while (exp_q.size() != 0 || ex_valid) @(negedge g_clk);
    endtask

    initial begin
        void'($urandom(26));
        rst          = 1'b1;
        flush        = 1'b0;
        id_valid     = 1'b0;
        id_opcode    = frv_pkg::OP;
        id_funct3    = '0;
        id_funct7_b5 = 1'b0;
        id_pc        = '0;
        id_rs1       = '0;
        id_rs2       = '0;
        id_imm       = '0;
        id_rd        = '0;
        wb_ready     = 1'b1;
        repeat (RST_CYCLES) @(negedge g_clk);
        rst = 1'b0;
        check_bit("ex_valid", ex_valid, 1'b0);

        run_phase(N_TIGHT, 1'b0);

        // Short reset with an instruction on offer
        rst = 1'b1;
        offer_random_instr();
        id_valid = 1'b1;
        repeat (2) @(negedge g_clk);
        rst      = 1'b0;
        id_valid = 1'b0;
        check_bit("ex_valid", ex_valid, 1'b0);

        run_phase(N_TIGHT + N_LOOSE, 1'b1);

        $display("Checks %0d, mismatches %0d, other errors %0d",
                 check_cnt, mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge g_clk);
        other_cnt++;
        $display("Timeout after %0d cycles with %0d instructions accepted",
                 WATCHDOG_CYCLES, accepted_cnt);
        $display("Checks %0d, mismatches %0d, other errors %0d",
                 check_cnt, mismatch_cnt, other_cnt);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+logic
logic/frv_pkg.sv
logic/frv_alu_op_if.sv
logic/frv_alu_decode.sv
logic/frv_alu.sv
logic/frv_branch_unit.sv
logic/frv_exec_reg.sv
logic/frv_execute.sv
testbench/tb_frv_execute.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the execute stage simulation with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_frv_execute -f list.f \
        -Mdir obj_dir -o sim_frv_execute; then
    echo "Verilator build failed"
    exit 1
fi

if ! output="$(./obj_dir/sim_frv_execute)"; then
    echo "$output"
    echo "Simulation exited with an error status"
    exit 1
fi
echo "$output"

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
